/* common/snake_pkg.sv */
package snake_pkg;

	// playfield geometry in pixels
	localparam int PLAY_W = 120;
	localparam int PLAY_H = 120;
	// border thickness on every edge
	localparam int WALL = 2;
	// apple coordinates fold into this range above the wall
	localparam int APPLE_SPAN = 100;

	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	typedef logic [6:0] len_t;

	// one snake segment or the apple
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
	} cell_t;

	typedef enum logic [1:0] {
		DIR_LEFT  = 2'b00,
		DIR_RIGHT = 2'b01,
		DIR_DOWN  = 2'b10,
		DIR_UP    = 2'b11
	} dir_e;

	// raw key levels, high while pressed
	typedef struct packed {
		logic left;
		logic right;
		logic down;
		logic up;
	} keys_t;

	// rgb bit order
	typedef enum logic [2:0] {
		COL_BLACK = 3'b000,
		COL_BLUE  = 3'b001,
		COL_GREEN = 3'b010,
		COL_RED   = 3'b100
	} colour_e;

	typedef struct packed {
		cell_t   pos;
		colour_e colour;
	} pixel_t;

	typedef enum logic [3:0] {
		ST_MENU,
		ST_START_HELD,
		ST_LOAD,
		ST_MAKE_APPLE,
		ST_DRAW,
		ST_WAIT_MOVE,
		ST_MOVE,
		ST_CHECK,
		ST_DEAD,
		ST_OVER
	} game_state_e;

	// start snake lies along row 20, body trailing to the right
	localparam cell_t START_HEAD = '{x: 8'd30, y: 7'd20};
	localparam len_t START_LEN = 7'd5;
	localparam dir_e START_DIR = DIR_LEFT;

	// true for cells in the wall band, also for wrapped coordinates
	function automatic logic in_border(input cell_t c);
		return (c.x < coord_x_t'(WALL)) || (c.x > coord_x_t'(PLAY_W - WALL - 1)) ||
			(c.y < coord_y_t'(WALL)) || (c.y > coord_y_t'(PLAY_H - WALL - 1));
	endfunction

endpackage

/* source/apple_source.sv */
module apple_source #(
	parameter logic [13:0] LFSR_SEED = 14'h2a5d
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             new_apple,
	output snake_pkg::cell_t apple
);
	import snake_pkg::*;

	localparam logic [6:0] SPAN = 7'(APPLE_SPAN);

	logic [13:0] lfsr;
	logic fb;

	// one subtraction is enough since the field stays below 2*SPAN
	function automatic logic [6:0] fold(input logic [6:0] f);
		if (f >= SPAN)
			return f - SPAN;
		return f;
	endfunction

	// fibonacci taps 13, 12, 11, 1
	assign fb = lfsr[13] ^ lfsr[12] ^ lfsr[11] ^ lfsr[1];

	// steps once per apple
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			lfsr <= LFSR_SEED;
		else if (new_apple)
			lfsr <= {lfsr[12:0], fb};
	end

	// low field gives x, high field gives y
	assign apple.x = coord_x_t'(WALL) + {1'b0, fold(lfsr[6:0])};
	assign apple.y = coord_y_t'(WALL) + fold(lfsr[13:7]);

endmodule

/* source/game_control.sv */
module game_control #(
	parameter int MOVE_TICKS = 8000000
) (
	input  logic             clk,
	input  logic             rst_n,
	input  snake_pkg::keys_t keys,
	input  logic             frame_done,
	input  logic             scan_done,
	input  logic             hit,
	input  logic             ate,
	output logic             load,
	output logic             step,
	output snake_pkg::dir_e  dir,
	output logic             scan,
	output logic             new_apple,
	output logic             frame_start,
	output logic             dead
);
	import snake_pkg::*;

	localparam int TICK_W = $clog2(MOVE_TICKS + 1);

	game_state_e state;
	game_state_e next_state;
	logic [TICK_W-1:0] tick_cnt;
	logic tick_last;
	logic any_key;
	// pending and applied direction
	dir_e pend_dir;
	dir_e cur_dir;
	dir_e eff_dir;
	dir_e key_dir;

	assign any_key = |keys;
	assign tick_last = (tick_cnt == TICK_W'(MOVE_TICKS - 1));

	always_comb
	begin
		next_state = state;
		case (state)
			ST_MENU: if (any_key) next_state = ST_START_HELD;
			// wait for release before loading
			ST_START_HELD: if (!any_key) next_state = ST_LOAD;
			ST_LOAD: next_state = ST_MAKE_APPLE;
			ST_MAKE_APPLE: next_state = ST_DRAW;
			ST_DRAW: if (frame_done) next_state = ST_WAIT_MOVE;
			ST_WAIT_MOVE: if (tick_last) next_state = ST_MOVE;
			// ate is valid here, one cycle after step
			ST_MOVE: next_state = ate ? ST_MAKE_APPLE : ST_CHECK;
			ST_CHECK: if (scan_done) next_state = hit ? ST_DEAD : ST_DRAW;
			ST_DEAD: next_state = ST_OVER;
			ST_OVER: if (any_key) next_state = ST_START_HELD;
			default: next_state = ST_MENU;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= ST_MENU;
		else
			state <= next_state;
	end

	// move pacing, runs only while waiting
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (state == ST_WAIT_MOVE && !tick_last)
			tick_cnt <= tick_cnt + 1'b1;
		else
			tick_cnt <= '0;
	end

	assign load = (state == ST_LOAD);
	assign new_apple = (state == ST_MAKE_APPLE);
	assign step = (state == ST_WAIT_MOVE) && tick_last;
	// an eating move skips the scan
	assign scan = (state == ST_MOVE) && !ate;
	assign frame_start = new_apple || ((state == ST_CHECK) && scan_done && !hit);
	assign dead = (state == ST_DEAD);

	// reversal is judged against the direction in force after this cycle
	assign eff_dir = step ? pend_dir : cur_dir;

	// key priority left, right, down, up
	always_comb
	begin
		key_dir = pend_dir;
		if (keys.left && eff_dir != DIR_RIGHT)
			key_dir = DIR_LEFT;
		else if (keys.right && eff_dir != DIR_LEFT)
			key_dir = DIR_RIGHT;
		else if (keys.down && eff_dir != DIR_UP)
			key_dir = DIR_DOWN;
		else if (keys.up && eff_dir != DIR_DOWN)
			key_dir = DIR_UP;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pend_dir <= START_DIR;
			cur_dir <= START_DIR;
		end
		else if (load)
		begin
			pend_dir <= START_DIR;
			cur_dir <= START_DIR;
		end
		else
		begin
			pend_dir <= key_dir;
			if (step)
				cur_dir <= pend_dir;
		end
	end

	// snake body moves with the pending direction at step
	assign dir = pend_dir;

endmodule

/* snake/snake_body.sv */
module snake_body #(
	parameter int MAX_LEN = 64
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic             step,
	input  snake_pkg::dir_e  dir,
	input  snake_pkg::cell_t apple,
	input  logic             scan,
	input  snake_pkg::len_t  seg_index,
	output snake_pkg::cell_t seg,
	output snake_pkg::len_t  length,
	output logic             ate,
	output logic             scan_done,
	output logic             hit
);
	import snake_pkg::*;

	localparam int IDX_W = $clog2(MAX_LEN);

	// head at index 0
	cell_t segs [MAX_LEN];
	cell_t head;
	cell_t new_head;
	logic on_apple;
	len_t scan_idx;
	logic scanning;
	logic self_hit;

	assign head = segs[0];
	assign seg = segs[seg_index[IDX_W-1:0]];
	assign on_apple = (new_head == apple);

	// next head one cell over, wraps into the wall band
	always_comb
	begin
		new_head = head;
		case (dir)
			DIR_LEFT: new_head.x = head.x - 1'b1;
			DIR_RIGHT: new_head.x = head.x + 1'b1;
			DIR_DOWN: new_head.y = head.y + 1'b1;
			default: new_head.y = head.y - 1'b1;
		endcase
	end

	// segment store, shifts toward the tail on every move
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			for (int i = 0; i < MAX_LEN; i++)
			begin
				segs[i].x <= START_HEAD.x + coord_x_t'(i);
				segs[i].y <= START_HEAD.y;
			end
		end
		else if (step)
		begin
			for (int i = MAX_LEN - 1; i > 0; i--)
				segs[i] <= segs[i-1];
			segs[0] <= new_head;
		end
	end

	// length, eat flag and the scan sequencer
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			length <= '0;
			ate <= 1'b0;
			scanning <= 1'b0;
			scan_idx <= '0;
			self_hit <= 1'b0;
		end
		else if (load)
		begin
			length <= START_LEN;
			ate <= 1'b0;
			scanning <= 1'b0;
			scan_idx <= '0;
			self_hit <= 1'b0;
		end
		else
		begin
			if (step)
			begin
				ate <= on_apple;
				// old tail stays in place when growing
				if (on_apple && length < len_t'(MAX_LEN))
					length <= length + 1'b1;
			end
			if (scan)
			begin
				scanning <= 1'b1;
				scan_idx <= '0;
				self_hit <= 1'b0;
			end
			else if (scanning)
			begin
				// index 0 is the head itself
				if (scan_idx != '0 && scan_idx < length && segs[scan_idx[IDX_W-1:0]] == head)
					self_hit <= 1'b1;
				if (scan_done)
					scanning <= 1'b0;
				else
					scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	// last scan cycle does the wall test
	assign scan_done = scanning && (scan_idx == length);
	assign hit = self_hit || in_border(head);

endmodule

/* render/frame_renderer.sv */
module frame_renderer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              frame_start,
	input  snake_pkg::cell_t  apple,
	input  snake_pkg::cell_t  seg,
	input  snake_pkg::len_t   length,
	output snake_pkg::len_t   seg_index,
	output snake_pkg::pixel_t pixel,
	output logic              plot,
	output logic              frame_done
);
	import snake_pkg::*;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_CLEAR,
		PH_BORDER,
		PH_APPLE,
		PH_SNAKE
	} phase_e;

	localparam coord_x_t X_LAST = coord_x_t'(PLAY_W - 1);
	localparam coord_y_t Y_LAST = coord_y_t'(PLAY_H - 1);

	phase_e phase;
	coord_x_t x_cnt;
	coord_y_t y_cnt;
	len_t snake_idx;
	cell_t scan_pos;
	logic scan_last;

	assign scan_pos = '{x: x_cnt, y: y_cnt};
	assign scan_last = (x_cnt == X_LAST) && (y_cnt == Y_LAST);
	assign seg_index = snake_idx;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= PH_IDLE;
			x_cnt <= '0;
			y_cnt <= '0;
			snake_idx <= '0;
			frame_done <= 1'b0;
		end
		else
		begin
			frame_done <= 1'b0;
			case (phase)
				PH_IDLE:
				begin
					if (frame_start)
					begin
						phase <= PH_CLEAR;
						x_cnt <= '0;
						y_cnt <= '0;
					end
				end
				// both full-field passes, y inner
				PH_CLEAR, PH_BORDER:
				begin
					if (y_cnt == Y_LAST)
					begin
						y_cnt <= '0;
						x_cnt <= x_cnt + 1'b1;
					end
					else
						y_cnt <= y_cnt + 1'b1;
					if (scan_last)
					begin
						x_cnt <= '0;
						phase <= (phase == PH_CLEAR) ? PH_BORDER : PH_APPLE;
					end
				end
				PH_APPLE:
				begin
					phase <= PH_SNAKE;
					snake_idx <= '0;
				end
				// head first, one segment per cycle
				PH_SNAKE:
				begin
					if (snake_idx == length - 1'b1)
					begin
						phase <= PH_IDLE;
						frame_done <= 1'b1;
					end
					else
						snake_idx <= snake_idx + 1'b1;
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// colour and plot per phase
	always_comb
	begin
		pixel.pos = scan_pos;
		pixel.colour = COL_BLACK;
		plot = 1'b0;
		case (phase)
			PH_CLEAR: plot = 1'b1;
			PH_BORDER:
			begin
				pixel.colour = COL_BLUE;
				plot = in_border(scan_pos);
			end
			PH_APPLE:
			begin
				pixel.pos = apple;
				pixel.colour = COL_RED;
				plot = 1'b1;
			end
			PH_SNAKE:
			begin
				pixel.pos = seg;
				pixel.colour = COL_GREEN;
				plot = 1'b1;
			end
			default: plot = 1'b0;
		endcase
	end

endmodule

/* source/snake_game.sv */
module snake_game #(
	parameter int MAX_LEN = 64,
	parameter int MOVE_TICKS = 8000000,
	parameter logic [13:0] LFSR_SEED = 14'h2a5d
) (
	input  logic              clk,
	input  logic              rst_n,
	input  snake_pkg::keys_t  keys,
	output snake_pkg::pixel_t pixel,
	output logic              plot,
	output logic              dead
);
	import snake_pkg::*;

	// control strobes
	logic load;
	logic step;
	logic scan;
	logic new_apple;
	logic frame_start;
	// status back to control
	logic frame_done;
	logic scan_done;
	logic hit;
	logic ate;

	dir_e  dir;
	cell_t apple;
	cell_t seg;
	len_t  length;
	len_t  seg_index;

	game_control #(
		.MOVE_TICKS(MOVE_TICKS)
	) i_game_control (
		.clk(clk),
		.rst_n(rst_n),
		.keys(keys),
		.frame_done(frame_done),
		.scan_done(scan_done),
		.hit(hit),
		.ate(ate),
		.load(load),
		.step(step),
		.dir(dir),
		.scan(scan),
		.new_apple(new_apple),
		.frame_start(frame_start),
		.dead(dead)
	);

	snake_body #(
		.MAX_LEN(MAX_LEN)
	) i_snake_body (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.step(step),
		.dir(dir),
		.apple(apple),
		.scan(scan),
		.seg_index(seg_index),
		.seg(seg),
		.length(length),
		.ate(ate),
		.scan_done(scan_done),
		.hit(hit)
	);

	apple_source #(
		.LFSR_SEED(LFSR_SEED)
	) i_apple_source (
		.clk(clk),
		.rst_n(rst_n),
		.new_apple(new_apple),
		.apple(apple)
	);

	frame_renderer i_frame_renderer (
		.clk(clk),
		.rst_n(rst_n),
		.frame_start(frame_start),
		.apple(apple),
		.seg(seg),
		.length(length),
		.seg_index(seg_index),
		.pixel(pixel),
		.plot(plot),
		.frame_done(frame_done)
	);

endmodule

/* tb/snake_game_assertions.sv */
module snake_game_assertions (
	input logic              clk,
	input logic              rst_n,
	input snake_pkg::pixel_t pixel,
	input logic              plot,
	input logic              dead
);
	import snake_pkg::*;

	// dead is a single-cycle pulse
	dead_single: assert property (@(posedge clk) disable iff (!rst_n) dead |=> !dead)
		else $error("dead held high for two cycles");

	// every plotted pixel inside the playfield
	plot_inside: assert property (@(posedge clk) disable iff (!rst_n)
		plot |-> (pixel.pos.x < coord_x_t'(PLAY_W)) && (pixel.pos.y < coord_y_t'(PLAY_H)))
		else $error("plotted pixel outside the playfield");

	// no drawing during the death pulse
	dead_quiet: assert property (@(posedge clk) disable iff (!rst_n) dead |-> !plot)
		else $error("plot high while dead pulses");

endmodule

bind snake_game snake_game_assertions i_snake_game_assertions (
	.clk(clk),
	.rst_n(rst_n),
	.pixel(pixel),
	.plot(plot),
	.dead(dead)
);

/* tb/tb_snake_game.sv */
module tb_snake_game;
	import snake_pkg::*;

	localparam int MAX_LEN = 64;
	localparam logic [13:0] LFSR_SEED = 14'h2a5d;
	localparam int FRAME_CYCLES = 2 * PLAY_W * PLAY_H + 200;

	logic clk;
	logic rst_n;
	keys_t keys;
	pixel_t pixel;
	logic plot;
	logic dead;

	// reference model state
	cell_t m_segs [MAX_LEN];
	int m_len;
	dir_e m_dir;
	logic [13:0] m_lfsr;
	cell_t m_apple;
	bit dead_seen;

	longint cycles;
	longint cycle_limit;
	string cmds [$];

	snake_game #(
		.MAX_LEN(MAX_LEN),
		.MOVE_TICKS(20),
		.LFSR_SEED(LFSR_SEED)
	) i_snake_game (
		.clk(clk),
		.rst_n(rst_n),
		.keys(keys),
		.pixel(pixel),
		.plot(plot),
		.dead(dead)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// watchdog limit is set once the command script is read
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles > cycle_limit)
		begin
			$display("Timeout: the run exceeded %0d cycles", cycle_limit);
			$display("Test failures found");
			$fatal(1);
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	function automatic bit on_wall(input int x, input int y);
		return (x < WALL) || (x > PLAY_W - WALL - 1) || (y < WALL) || (y > PLAY_H - WALL - 1);
	endfunction

	function automatic int fold_span(input int f);
		return (f >= APPLE_SPAN) ? f - APPLE_SPAN : f;
	endfunction

	// fibonacci step on taps 13 12 11 1 and the new apple from it
	task automatic next_apple();
		logic fb;
		fb = m_lfsr[13] ^ m_lfsr[12] ^ m_lfsr[11] ^ m_lfsr[1];
		m_lfsr = {m_lfsr[12:0], fb};
		m_apple.x = coord_x_t'(WALL + fold_span(int'(m_lfsr[6:0])));
		m_apple.y = coord_y_t'(WALL + fold_span(int'(m_lfsr[13:7])));
	endtask

	function automatic cell_t cell_after(input cell_t c, input dir_e d);
		cell_t n;
		n = c;
		case (d)
			DIR_LEFT: n.x = c.x - 1'b1;
			DIR_RIGHT: n.x = c.x + 1'b1;
			DIR_DOWN: n.y = c.y + 1'b1;
			default: n.y = c.y - 1'b1;
		endcase
		return n;
	endfunction

	function automatic bit is_reverse(input dir_e a, input dir_e b);
		return (a == DIR_LEFT && b == DIR_RIGHT) || (a == DIR_RIGHT && b == DIR_LEFT) ||
			(a == DIR_UP && b == DIR_DOWN) || (a == DIR_DOWN && b == DIR_UP);
	endfunction

	function automatic keys_t key_of(input dir_e d);
		keys_t k;
		k = '0;
		case (d)
			DIR_LEFT: k.left = 1'b1;
			DIR_RIGHT: k.right = 1'b1;
			DIR_DOWN: k.down = 1'b1;
			default: k.up = 1'b1;
		endcase
		return k;
	endfunction

	task automatic reset_model();
		for (int i = 0; i < MAX_LEN; i++)
		begin
			m_segs[i].x = START_HEAD.x + coord_x_t'(i);
			m_segs[i].y = START_HEAD.y;
		end
		m_len = int'(START_LEN);
		m_dir = START_DIR;
		next_apple();
	endtask

	// one move of the model with the held keys
	task automatic move_model(input keys_t k, output bit ate, output bit died);
		cell_t nh;
		if (k.left && m_dir != DIR_RIGHT)
			m_dir = DIR_LEFT;
		else if (k.right && m_dir != DIR_LEFT)
			m_dir = DIR_RIGHT;
		else if (k.down && m_dir != DIR_UP)
			m_dir = DIR_DOWN;
		else if (k.up && m_dir != DIR_DOWN)
			m_dir = DIR_UP;
		nh = cell_after(m_segs[0], m_dir);
		for (int i = MAX_LEN - 1; i > 0; i--)
			m_segs[i] = m_segs[i-1];
		m_segs[0] = nh;
		ate = (nh == m_apple);
		died = 1'b0;
		if (ate)
		begin
			if (m_len < MAX_LEN)
				m_len++;
			next_apple();
		end
		else
		begin
			died = on_wall(int'(nh.x), int'(nh.y));
			for (int i = 1; i < m_len; i++)
				if (m_segs[i] == nh)
					died = 1'b1;
		end
	endtask

	// whole frame checked cycle by cycle against the model
	task automatic check_frame();
		pixel_t exp;
		bit b;
		while (!plot)
		begin
			check("dead", 32'(dead), 32'd0);
			@(negedge clk);
		end
		for (int x = 0; x < PLAY_W; x++)
			for (int y = 0; y < PLAY_H; y++)
			begin
				exp.pos.x = coord_x_t'(x);
				exp.pos.y = coord_y_t'(y);
				exp.colour = COL_BLACK;
				check("plot", 32'(plot), 32'd1);
				check("pixel", 32'(pixel), 32'(exp));
				@(negedge clk);
			end
		// border pass plots only the wall band
		for (int x = 0; x < PLAY_W; x++)
			for (int y = 0; y < PLAY_H; y++)
			begin
				b = on_wall(x, y);
				exp.pos.x = coord_x_t'(x);
				exp.pos.y = coord_y_t'(y);
				exp.colour = COL_BLUE;
				check("plot", 32'(plot), 32'(b));
				if (b)
					check("pixel", 32'(pixel), 32'(exp));
				@(negedge clk);
			end
		exp.pos = m_apple;
		exp.colour = COL_RED;
		check("plot", 32'(plot), 32'd1);
		check("pixel", 32'(pixel), 32'(exp));
		@(negedge clk);
		// head first
		for (int i = 0; i < m_len; i++)
		begin
			exp.pos = m_segs[i];
			exp.colour = COL_GREEN;
			check("plot", 32'(plot), 32'd1);
			check("pixel", 32'(pixel), 32'(exp));
			@(negedge clk);
		end
		check("plot", 32'(plot), 32'd0);
	endtask

	task automatic wait_dead();
		@(negedge clk);
		while (!dead)
		begin
			check("plot", 32'(plot), 32'd0);
			@(negedge clk);
		end
		// release before the over state looks at the keys
		keys = '0;
		@(negedge clk);
		check("dead", 32'(dead), 32'd0);
		dead_seen = 1'b1;
	endtask

	// press and release after an idle gap and check the first frame
	task automatic start_game();
		int gap;
		gap = 5 + int'($urandom % 16);
		keys = '0;
		repeat (gap)
		begin
			check("plot", 32'(plot), 32'd0);
			check("dead", 32'(dead), 32'd0);
			@(negedge clk);
		end
		keys.up = 1'b1;
		// held key alone starts nothing
		gap = 5 + int'($urandom % 16);
		repeat (gap)
		begin
			check("plot", 32'(plot), 32'd0);
			@(negedge clk);
		end
		keys = '0;
		reset_model();
		check_frame();
	endtask

	task automatic do_move(input keys_t k, output bit ate);
		bit died;
		keys = k;
		move_model(k, ate, died);
		if (died)
			wait_dead();
		else
			check_frame();
	endtask

	task automatic hold_dir(input keys_t k, input int moves);
		bit ate;
		for (int i = 0; i < moves && !dead_seen; i++)
			do_move(k, ate);
	endtask

	// whether the next head cell is safe in the model
	function automatic bit safe_step(input dir_e d);
		cell_t n;
		n = cell_after(m_segs[0], d);
		if (is_reverse(d, m_dir) || on_wall(int'(n.x), int'(n.y)))
			return 1'b0;
		for (int i = 0; i < m_len - 1; i++)
			if (m_segs[i] == n)
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic seek_apple();
		dir_e cand [6];
		dir_e pick;
		bit ate;
		int moves;
		ate = 1'b0;
		moves = 0;
		while (!ate)
		begin
			cand[0] = (m_apple.x < m_segs[0].x) ? DIR_LEFT : DIR_RIGHT;
			cand[1] = (m_apple.y < m_segs[0].y) ? DIR_UP : DIR_DOWN;
			if (m_apple.x == m_segs[0].x)
				cand[0] = cand[1];
			if (m_apple.y == m_segs[0].y)
				cand[1] = cand[0];
			cand[2] = DIR_LEFT;
			cand[3] = DIR_RIGHT;
			cand[4] = DIR_DOWN;
			cand[5] = DIR_UP;
			pick = m_dir;
			for (int i = 5; i >= 0; i--)
				if (safe_step(cand[i]))
					pick = cand[i];
			do_move(key_of(pick), ate);
			if (dead_seen)
				abort_run("snake died while seeking the apple");
			moves++;
			if (moves > 300)
				abort_run("seek did not reach the apple");
		end
	endtask

	function automatic keys_t key_from_word(input logic [8*16-1:0] w);
		if (w == "left")
			return key_of(DIR_LEFT);
		if (w == "right")
			return key_of(DIR_RIGHT);
		if (w == "down")
			return key_of(DIR_DOWN);
		return key_of(DIR_UP);
	endfunction

	initial
	begin
		int fd;
		int n;
		string line;
		logic [8*16-1:0] w0;
		logic [8*16-1:0] w1;
		int count;
		cycles = 0;
		cycle_limit = 0;
		dead_seen = 1'b0;
		m_lfsr = LFSR_SEED;
		rst_n = 1'b0;
		keys = '0;
		void'($urandom(32'h0e1d_f8b2));
		fd = $fopen("tb/snake_tests.txt", "r");
		if (fd == 0)
			abort_run("cannot open tb/snake_tests.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#")
				cmds.push_back(line);
		end
		$fclose(fd);
		cycle_limit = longint'(cmds.size()) * 40 * FRAME_CYCLES;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		foreach (cmds[i])
		begin
			w0 = '0;
			w1 = '0;
			count = 0;
			n = $sscanf(cmds[i], "%s %s %d", w0, w1, count);
			if (w0 == "start")
				start_game();
			else if (w0 == "restart")
			begin
				if (!dead_seen)
					abort_run("restart issued while the game is still running");
				dead_seen = 1'b0;
				start_game();
			end
			else if (w0 == "hold")
			begin
				if (n != 3)
					abort_run({"hold command lacks a direction or a count: ", cmds[i]});
				hold_dir(key_from_word(w1), count);
			end
			else if (w0 == "seek")
				seek_apple();
			else if (w0 == "expect_dead")
			begin
				if (!dead_seen)
					abort_run("expected death did not occur");
			end
			else
				abort_run({"unknown command in script: ", cmds[i]});
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

/* tb/snake_tests.txt */
# command [direction] [moves]
# start | restart | hold <left|right|down|up> <moves> | seek | expect_dead
start
hold left 3
hold up 4
hold down 2
hold right 3
seek
hold up 150
expect_dead
restart
hold left 1
hold up 1
hold right 1
hold down 1
expect_dead
restart
hold left 40
expect_dead

/* vlog.f */
common/snake_pkg.sv
source/apple_source.sv
source/game_control.sv
snake/snake_body.sv
render/frame_renderer.sv
source/snake_game.sv
tb/snake_game_assertions.sv
tb/tb_snake_game.sv

/* run_sim.sh */
#!/bin/bash
# build and run the snake game testbench, exit status reports the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_snake_game -f vlog.f -o sim_snake \
	&& ./obj_dir/sim_snake \
	|| exit 1
